// File: cpu_bus_pkg.sv
// CPU bus package
// 68000 bus widths, the two mode register addresses on the word bus
// and the autovector levels of the video interrupts

package cpu_bus_pkg;

    // ==========================================================
    // Bus types
    // ==========================================================
    typedef logic [23:1] addr_t;  // Word address, A0 is implied by UDS/LDS
    typedef logic [15:0] word_t;
    typedef logic [2:0]  fc_t;

    // ==========================================================
    // Register map
    // ==========================================================
    localparam addr_t SYNC_MODE_ADDR  = 23'h7F_C105;  // FF820A
    localparam addr_t SHIFT_MODE_ADDR = 23'h7F_C130;  // FF8260

    // Autovector levels, compared against A3..A1 during IACK
    localparam logic [2:0] HBL_LEVEL = 3'd2;
    localparam logic [2:0] VBL_LEVEL = 3'd4;

endpackage

// File: video_timing_pkg.sv
// Video timing package
// Counter types and the decode points of the sync, blank and
// display-enable generators, given in m2 periods or in lines

package video_timing_pkg;

    typedef logic [6:0] hcount_t;    // Horizontal sync counter
    typedef logic [9:0] vcount_t;    // Vertical sync counter
    typedef logic [7:0] hdecount_t;  // Horizontal DE counter
    typedef logic [9:0] vdecount_t;  // Vertical DE counter

    // ==========================================================
    // Sync counters
    // ==========================================================
    localparam hcount_t HCOUNT_LAST      = 7'd127;
    localparam hcount_t HLOAD_PAL        = 7'd1;    // 128 periods per line
    localparam hcount_t HLOAD_NTSC       = 7'd2;    // 127
    localparam hcount_t HLOAD_MONO       = 7'd73;   // 56
    localparam hcount_t HSYNC_SET_COLOUR = 7'd101;
    localparam hcount_t HSYNC_RES_COLOUR = 7'd111;
    localparam hcount_t HSYNC_SET_MONO   = 7'd121;
    localparam hcount_t HSYNC_RES_MONO   = 7'd127;

    localparam vcount_t VCOUNT_LAST      = 10'd511;
    localparam vcount_t VLOAD_PAL        = 10'd200;  // 313 lines
    localparam vcount_t VLOAD_NTSC       = 10'd250;  // 263 lines
    localparam vcount_t VLOAD_MONO       = 10'd12;
    localparam vcount_t VLOAD_MONO60     = 10'd939;
    localparam vcount_t VSYNC_SET_COLOUR = 10'd508;
    localparam vcount_t VSYNC_SET_MONO   = 10'd510;

    // ==========================================================
    // Display enable and blank
    // ==========================================================
    localparam hdecount_t HDE_SET_PAL  = 8'd12;
    localparam hdecount_t HDE_RES_PAL  = 8'd96;
    localparam hdecount_t HDE_SET_NTSC = 8'd11;
    localparam hdecount_t HDE_RES_NTSC = 8'd95;
    localparam hdecount_t HDE_SET_MONO = 8'd2;
    localparam hdecount_t HDE_RES_MONO = 8'd43;

    // Points where BLANK_N goes high and low again
    localparam hdecount_t HBLANK_SET_PAL  = 8'd9;
    localparam hdecount_t HBLANK_SET_NTSC = 8'd8;
    localparam hdecount_t HBLANK_RESET    = 8'd114;

    localparam vdecount_t VDE_SET_PAL    = 10'd62;
    localparam vdecount_t VDE_RES_PAL    = 10'd262;
    localparam vdecount_t VDE_SET_NTSC   = 10'd33;
    localparam vdecount_t VDE_RES_NTSC   = 10'd233;
    localparam vdecount_t VDE_SET_MONO   = 10'd35;
    localparam vdecount_t VDE_RES_MONO   = 10'd435;
    localparam vdecount_t VDE_SET_MONO60 = 10'd120;
    localparam vdecount_t VDE_RES_MONO60 = 10'd520;

    localparam vdecount_t VBLANK_SET_PAL  = 10'd24;
    localparam vdecount_t VBLANK_SET_NTSC = 10'd15;
    localparam vdecount_t VBLANK_RES_PAL  = 10'd307;
    localparam vdecount_t VBLANK_RES_NTSC = 10'd257;

endpackage

// File: clock_enables.sv
// m2 clock enables
// Splits clk32 into the rising and falling phase enables of the
// 2 MHz pixel timing clock, one pulse each per M2_DIV cycles

`timescale 1ns/1ps

module clock_enables #(
    parameter int M2_DIV = 16
) (
    input  logic clk32,
    input  logic porb,
    output logic m2_en_p_o,
    output logic m2_en_n_o
);

    localparam int PW = $clog2(M2_DIV);

    logic [PW-1:0] phase;

    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) begin
            phase     <= '0;
            m2_en_p_o <= 1'b0;
            m2_en_n_o <= 1'b0;
        end else begin
            if (phase == PW'(M2_DIV - 1)) phase <= '0;
            else phase <= phase + 1'b1;
            m2_en_p_o <= (phase == PW'(M2_DIV - 1));     // End of period
            m2_en_n_o <= (phase == PW'(M2_DIV / 2 - 1)); // Half way
        end
    end

endmodule

// File: bus_regs.sv
// CPU bus registers
// Decodes the sync mode and shifter mode registers for the 68000,
// answers with DTACK, and raises HBL/VBL on the sync rising edges.
// An autovector acknowledge answers with VPA and clears the request

`timescale 1ns/1ps

module bus_regs (
    input  logic                clk32,
    input  logic                porb,
    input  logic                as_n_i,
    input  logic                rw_i,
    input  logic                uds_n_i,
    input  cpu_bus_pkg::fc_t    fc_i,
    input  cpu_bus_pkg::addr_t  addr_i,
    input  cpu_bus_pkg::word_t  data_i,
    output cpu_bus_pkg::word_t  data_o,
    output logic                dtack_n_o,
    output logic                vpa_n_o,
    input  logic                mfpint_n_i,
    input  logic                hsync_n_i,
    input  logic                vsync_n_i,
    output logic                ipl1_n_o,
    output logic                ipl2_n_o,
    output logic                mde1_o,
    output logic                mde0_o,
    output logic                pal_o
);

    logic data_cyc, iack;
    logic sync_sel, mode_sel, wr_en;
    logic hbl_ack, vbl_ack;
    logic hsync_d, vsync_d;
    logic hbl_pend, vbl_pend;

    // ==========================================================
    // Cycle decode
    // ==========================================================
    assign data_cyc = !as_n_i && (fc_i != 3'd7);
    assign iack     = !as_n_i && (fc_i == 3'd7);
    assign sync_sel = data_cyc && (addr_i == cpu_bus_pkg::SYNC_MODE_ADDR);
    assign mode_sel = data_cyc && (addr_i == cpu_bus_pkg::SHIFT_MODE_ADDR);
    assign wr_en    = !rw_i && !uds_n_i;   // Both registers live in the upper byte

    assign hbl_ack = iack && (addr_i[3:1] == cpu_bus_pkg::HBL_LEVEL);
    assign vbl_ack = iack && (addr_i[3:1] == cpu_bus_pkg::VBL_LEVEL);

    assign dtack_n_o = !(sync_sel || mode_sel);
    assign vpa_n_o   = !(hbl_ack || vbl_ack);

    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) begin
            pal_o  <= 1'b0;
            mde1_o <= 1'b0;
            mde0_o <= 1'b0;
        end else begin
            if (sync_sel && wr_en) pal_o <= data_i[9];
            if (mode_sel && wr_en) {mde1_o, mde0_o} <= data_i[9:8];
        end
    end

    // Unused bits float high on the real bus
    always_comb begin
        data_o = '1;
        if (rw_i && sync_sel) data_o[9:8] = {pal_o, 1'b0};
        if (rw_i && mode_sel) data_o[9:8] = {mde1_o, mde0_o};
    end

    // ==========================================================
    // HBL and VBL requests
    // ==========================================================
    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) begin
            hsync_d  <= 1'b1;
            vsync_d  <= 1'b1;
            hbl_pend <= 1'b0;
            vbl_pend <= 1'b0;
        end else begin
            hsync_d <= hsync_n_i;
            vsync_d <= vsync_n_i;
            if (hbl_ack) hbl_pend <= 1'b0;          // Acknowledge wins
            else if (hsync_n_i && !hsync_d) hbl_pend <= 1'b1;
            if (vbl_ack) vbl_pend <= 1'b0;
            else if (vsync_n_i && !vsync_d) vbl_pend <= 1'b1;
        end
    end

    // VBL is level 4, HBL level 2, MFP pulls all lines to level 6
    assign ipl2_n_o = mfpint_n_i && !vbl_pend;
    assign ipl1_n_o = mfpint_n_i && (!hbl_pend || vbl_pend);

endmodule

// File: hsync_gen.sv
// Horizontal sync generator
// 7-bit counter on the m2 rising enable, reloaded twice at the end
// of the line with a mode value that sets the line length

`timescale 1ns/1ps

module hsync_gen (
    input  logic clk32,
    input  logic porb,
    input  logic m2_en_p_i,
    input  logic mde1_i,
    input  logic pal_i,
    output logic hsync_n_o,
    output logic hsync_start_o,
    output logic line_end_o,
    output logic vert_en_o
);

    video_timing_pkg::hcount_t hsc, load_val, sync_set, sync_res;
    logic                      hsc_load;   // Second reload pending

    assign load_val = mde1_i ? video_timing_pkg::HLOAD_MONO :
                      pal_i  ? video_timing_pkg::HLOAD_PAL : video_timing_pkg::HLOAD_NTSC;
    assign sync_set = mde1_i ? video_timing_pkg::HSYNC_SET_MONO
                             : video_timing_pkg::HSYNC_SET_COLOUR;
    assign sync_res = mde1_i ? video_timing_pkg::HSYNC_RES_MONO
                             : video_timing_pkg::HSYNC_RES_COLOUR;

    assign hsync_start_o = m2_en_p_i && (hsc == sync_set);
    assign line_end_o    = m2_en_p_i && (hsc == sync_res);
    assign vert_en_o     = m2_en_p_i && hsc_load;   // One per line

    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) begin
            hsc       <= '0;
            hsc_load  <= 1'b0;
            hsync_n_o <= 1'b1;
        end else if (m2_en_p_i) begin
            if (hsc == video_timing_pkg::HCOUNT_LAST || hsc_load) begin
                hsc      <= load_val;
                hsc_load <= !hsc_load;
            end else begin
                hsc <= hsc + 1'b1;
            end
            if (hsc == sync_set) hsync_n_o <= 1'b0;
            else if (hsc == sync_res) hsync_n_o <= 1'b1;
        end
    end

endmodule

// File: vsync_gen.sv
// Vertical sync generator
// Line counter with the STE double reload, so a mode change made
// after the first reload still sets the length of the next frame

`timescale 1ns/1ps

module vsync_gen (
    input  logic clk32,
    input  logic porb,
    input  logic vert_en_i,
    input  logic mde1_i,
    input  logic pal_i,
    input  logic mde60_i,
    output logic vsync_n_o,
    output logic frame_start_o
);

    video_timing_pkg::vcount_t vsc, load_val, sync_set;
    logic                      vsc_load;

    always_comb begin
        if (mde1_i)
            load_val = mde60_i ? video_timing_pkg::VLOAD_MONO60 : video_timing_pkg::VLOAD_MONO;
        else
            load_val = pal_i ? video_timing_pkg::VLOAD_PAL : video_timing_pkg::VLOAD_NTSC;
    end

    assign sync_set = mde1_i ? video_timing_pkg::VSYNC_SET_MONO
                             : video_timing_pkg::VSYNC_SET_COLOUR;

    assign frame_start_o = vert_en_i && (vsc == sync_set);

    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) begin
            vsc       <= '0;
            vsc_load  <= 1'b1;   // Take a valid count on the first line
            vsync_n_o <= 1'b1;
        end else if (vert_en_i) begin
            if (vsc == video_timing_pkg::VCOUNT_LAST || vsc_load) begin
                vsc      <= load_val;
                vsc_load <= !vsc_load;
                if (vsc_load) vsync_n_o <= 1'b1;   // VSYNC ends with the second reload
            end else begin
                vsc <= vsc + 1'b1;
                if (vsc == sync_set) vsync_n_o <= 1'b0;
            end
        end
    end

endmodule

// File: de_gen.sv
// Display enable and blank generator
// Counts m2 periods from HSYNC and lines from VSYNC to frame the
// active window and the blanking, then registers DE and BLANK_N

`timescale 1ns/1ps

module de_gen (
    input  logic clk32,
    input  logic porb,
    input  logic m2_en_p_i,
    input  logic m2_en_n_i,
    input  logic hsync_start_i,
    input  logic line_end_i,
    input  logic frame_start_i,
    input  logic mde1_i,
    input  logic mde0_i,
    input  logic pal_i,
    input  logic mde60_i,
    output logic de_o,
    output logic blank_n_o
);

    video_timing_pkg::hdecount_t hdec, hde_set, hde_res, hblank_set;
    video_timing_pkg::vdecount_t vdec, vde_set, vde_res, vblank_set, vblank_res;
    logic                        hde, vde, hblank_n, vblank_n;

    // ==========================================================
    // Decode points of the current mode
    // ==========================================================
    always_comb begin
        if (mde1_i) begin
            hde_set = video_timing_pkg::HDE_SET_MONO;
            hde_res = video_timing_pkg::HDE_RES_MONO;
            vde_set = mde60_i ? video_timing_pkg::VDE_SET_MONO60
                              : video_timing_pkg::VDE_SET_MONO;
            vde_res = mde60_i ? video_timing_pkg::VDE_RES_MONO60
                              : video_timing_pkg::VDE_RES_MONO;
        end else if (pal_i) begin
            hde_set = video_timing_pkg::HDE_SET_PAL;
            hde_res = video_timing_pkg::HDE_RES_PAL;
            vde_set = video_timing_pkg::VDE_SET_PAL;
            vde_res = video_timing_pkg::VDE_RES_PAL;
        end else begin
            hde_set = video_timing_pkg::HDE_SET_NTSC;
            hde_res = video_timing_pkg::HDE_RES_NTSC;
            vde_set = video_timing_pkg::VDE_SET_NTSC;
            vde_res = video_timing_pkg::VDE_RES_NTSC;
        end
        if (mde0_i) hde_set = hde_set + 8'd2;   // Medium resolution starts later
    end

    assign hblank_set = pal_i ? video_timing_pkg::HBLANK_SET_PAL
                              : video_timing_pkg::HBLANK_SET_NTSC;
    assign vblank_set = pal_i ? video_timing_pkg::VBLANK_SET_PAL
                              : video_timing_pkg::VBLANK_SET_NTSC;
    assign vblank_res = pal_i ? video_timing_pkg::VBLANK_RES_PAL
                              : video_timing_pkg::VBLANK_RES_NTSC;

    assign hde      = (hdec >= hde_set) && (hdec < hde_res);
    assign vde      = (vdec >= vde_set) && (vdec < vde_res);
    assign hblank_n = (hdec >= hblank_set) && (hdec < video_timing_pkg::HBLANK_RESET);
    assign vblank_n = (vdec >= vblank_set) && (vdec < vblank_res);

    // ==========================================================
    // Counters and output register
    // ==========================================================
    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) begin
            hdec <= '0;
            vdec <= '0;
        end else begin
            if (hsync_start_i) hdec <= '0;
            else if (m2_en_n_i) hdec <= hdec + 1'b1;
            if (frame_start_i) vdec <= '0;
            else if (line_end_i) vdec <= vdec + 1'b1;
        end
    end

    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) begin
            de_o      <= 1'b1;
            blank_n_o <= 1'b1;
        end else if (m2_en_p_i) begin
            de_o      <= hde && vde;
            blank_n_o <= mde1_i || (hblank_n && vblank_n);   // Mono monitor has no blanking
        end
    end

endmodule

// File: gstmcu_video.sv
// GSTMCU video timing top level
// 68000 register front end, m2 enables, horizontal and vertical
// sync, display enable and blank, and the HBL/VBL interrupts

`timescale 1ns/1ps

module gstmcu_video #(
    parameter int M2_DIV = 16
) (
    input  logic                clk32,
    input  logic                porb,
    input  logic                as_n_i,
    input  logic                rw_i,
    input  logic                uds_n_i,
    input  cpu_bus_pkg::fc_t    fc_i,
    input  cpu_bus_pkg::addr_t  addr_i,
    input  cpu_bus_pkg::word_t  data_i,
    output cpu_bus_pkg::word_t  data_o,
    output logic                dtack_n_o,
    output logic                vpa_n_o,
    input  logic                mfpint_n_i,
    input  logic                mde60_i,
    output logic                ipl1_n_o,
    output logic                ipl2_n_o,
    output logic                hsync_n_o,
    output logic                vsync_n_o,
    output logic                de_o,
    output logic                blank_n_o,
    output logic                pal_o
);

    logic m2_en_p, m2_en_n;
    logic mde1, mde0;
    logic hsync_start, line_end, vert_en, frame_start;

    clock_enables #(.M2_DIV(M2_DIV)) clock_enables_i (
        .clk32(clk32), .porb(porb), .m2_en_p_o(m2_en_p), .m2_en_n_o(m2_en_n)
    );

    bus_regs bus_regs_i (
        .clk32(clk32), .porb(porb),
        .as_n_i(as_n_i), .rw_i(rw_i), .uds_n_i(uds_n_i), .fc_i(fc_i),
        .addr_i(addr_i), .data_i(data_i), .data_o(data_o),
        .dtack_n_o(dtack_n_o), .vpa_n_o(vpa_n_o), .mfpint_n_i(mfpint_n_i),
        .hsync_n_i(hsync_n_o), .vsync_n_i(vsync_n_o),
        .ipl1_n_o(ipl1_n_o), .ipl2_n_o(ipl2_n_o),
        .mde1_o(mde1), .mde0_o(mde0), .pal_o(pal_o)
    );

    hsync_gen hsync_gen_i (
        .clk32(clk32), .porb(porb), .m2_en_p_i(m2_en_p),
        .mde1_i(mde1), .pal_i(pal_o),
        .hsync_n_o(hsync_n_o), .hsync_start_o(hsync_start),
        .line_end_o(line_end), .vert_en_o(vert_en)
    );

    vsync_gen vsync_gen_i (
        .clk32(clk32), .porb(porb), .vert_en_i(vert_en),
        .mde1_i(mde1), .pal_i(pal_o), .mde60_i(mde60_i),
        .vsync_n_o(vsync_n_o), .frame_start_o(frame_start)
    );

    de_gen de_gen_i (
        .clk32(clk32), .porb(porb), .m2_en_p_i(m2_en_p), .m2_en_n_i(m2_en_n),
        .hsync_start_i(hsync_start), .line_end_i(line_end),
        .frame_start_i(frame_start),
        .mde1_i(mde1), .mde0_i(mde0), .pal_i(pal_o), .mde60_i(mde60_i),
        .de_o(de_o), .blank_n_o(blank_n_o)
    );

endmodule

// File: tb_clock.sv
// Testbench clock
// Free-running clk32 with a fixed period

`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS = 20
) (
    output logic clk_o
);

    initial clk_o = 1'b0;

    always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

// File: gstmcu_asserts.sv
// Video timing bus and sync checks
// Bound to the top level; DTACK and VPA qualification and the
// shortest HSYNC low pulse

`timescale 1ns/1ps

module gstmcu_asserts #(
    parameter int M2_DIV = 16
) (
    input logic             clk32,
    input logic             porb,
    input logic             as_n_i,
    input cpu_bus_pkg::fc_t fc_i,
    input logic             dtack_n_i,
    input logic             vpa_n_i,
    input logic             hsync_n_i
);

    localparam int MIN_LOW = 6 * M2_DIV;  // Mono sync width

    int          fail_count = 0;
    logic [15:0] low_len;

    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) low_len <= '0;
        else if (hsync_n_i) low_len <= '0;
        else low_len <= low_len + 1'b1;
    end

    dtack_qualified: assert property (@(posedge clk32) disable iff (!porb)
        !dtack_n_i |-> !as_n_i)
        else begin
            $error("DTACK low while the address strobe is high");
            fail_count++;
        end

    vpa_qualified: assert property (@(posedge clk32) disable iff (!porb)
        !vpa_n_i |-> (fc_i == 3'd7))
        else begin
            $error("VPA low outside an interrupt acknowledge");
            fail_count++;
        end

    hsync_width: assert property (@(posedge clk32) disable iff (!porb)
        $rose(hsync_n_i) |-> (low_len >= 16'(MIN_LOW)))
        else begin
            $error("HSYNC low pulse of %0d cycles is too short", low_len);
            fail_count++;
        end

endmodule

bind gstmcu_video gstmcu_asserts #(.M2_DIV(M2_DIV)) gstmcu_asserts_i (
    .clk32(clk32), .porb(porb), .as_n_i(as_n_i), .fc_i(fc_i),
    .dtack_n_i(dtack_n_o), .vpa_n_i(vpa_n_o), .hsync_n_i(hsync_n_o)
);

// File: tb_gstmcu.sv
// GSTMCU video timing testbench
// Drives the 68000 bus on the falling clk32 edge, measures sync and
// display-enable timing in clk32 cycles and checks the interrupts

`timescale 1ns/1ps

module tb_gstmcu;

    localparam int CLK_NS    = 20;
    localparam int M2_DIV    = 16;
    localparam int LINE_CYC  = 128 * M2_DIV;     // PAL line
    localparam int FRAME_CYC = 313 * LINE_CYC;
    // Test 2 needs about 16 lines, tests 3 to 5 under 6 frames
    localparam longint WATCHDOG_NS =
        64'(CLK_NS) * (6 * FRAME_CYC + 16 * LINE_CYC) * 11 / 10;

    localparam cpu_bus_pkg::fc_t FC_DATA = 3'd5;
    localparam cpu_bus_pkg::fc_t FC_IACK = 3'd7;
    localparam int SEL_HSYNC = 0;
    localparam int SEL_VSYNC = 1;

    logic clk32, porb, as_n, rw, uds_n, mfpint_n, mde60;
    cpu_bus_pkg::fc_t   fc;
    cpu_bus_pkg::addr_t addr;
    cpu_bus_pkg::word_t wdata, rdata;
    logic dtack_n, vpa_n, ipl1_n, ipl2_n, hsync_n, vsync_n, de, blank_n, pal;

    longint      cyc = 0;
    logic [31:0] rng = 32'h630e_5444;
    int          tests = 0, failed = 0, checks = 0, errors = 0, test_errs = 0;

    tb_clock #(.PERIOD_NS(CLK_NS)) tb_clock_i (.clk_o(clk32));

    gstmcu_video #(.M2_DIV(M2_DIV)) gstmcu_video_i (
        .clk32(clk32), .porb(porb), .as_n_i(as_n), .rw_i(rw), .uds_n_i(uds_n),
        .fc_i(fc), .addr_i(addr), .data_i(wdata), .data_o(rdata),
        .dtack_n_o(dtack_n), .vpa_n_o(vpa_n), .mfpint_n_i(mfpint_n), .mde60_i(mde60),
        .ipl1_n_o(ipl1_n), .ipl2_n_o(ipl2_n), .hsync_n_o(hsync_n), .vsync_n_o(vsync_n),
        .de_o(de), .blank_n_o(blank_n), .pal_o(pal)
    );

    always @(posedge clk32) cyc <= cyc + 1;

    // ==========================================================
    // Helpers
    // ==========================================================
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic probe(input int sel);
        return (sel == SEL_HSYNC) ? hsync_n : vsync_n;
    endfunction

    task automatic flag_error(input string msg);
        $display("error at %0d ns: %s", $time, msg);
        errors++;
        test_errs++;
    endtask

    task automatic check(input logic ok, input string msg);
        checks++;
        assert (ok) else flag_error(msg);
    endtask

    task automatic end_test(input string name);
        tests++;
        if (test_errs != 0) failed++;
        $display("test %0d %-20s %s", tests, name, (test_errs == 0) ? "ok" : "FAILED");
        test_errs = 0;
    endtask

    // One 68000 cycle, strobes held across one rising edge
    task automatic bus_cycle(input cpu_bus_pkg::addr_t a, input logic wr,
                             input cpu_bus_pkg::word_t wd, input cpu_bus_pkg::fc_t f,
                             output cpu_bus_pkg::word_t rd, output logic dt, output logic vp);
        @(negedge clk32);
        addr  = a;
        fc    = f;
        wdata = wd;
        rw    = !wr;
        uds_n = 1'b0;
        as_n  = 1'b0;
        @(negedge clk32);
        rd    = rdata;
        dt    = !dtack_n;
        vp    = !vpa_n;
        as_n  = 1'b1;
        uds_n = 1'b1;
        rw    = 1'b1;
    endtask

    task automatic set_mode(input logic pal_bit, input logic [1:0] shift);
        cpu_bus_pkg::word_t rd;
        logic dt, vp;
        bus_cycle(cpu_bus_pkg::SYNC_MODE_ADDR, 1'b1, {6'h0, pal_bit, 9'h0}, FC_DATA, rd, dt, vp);
        bus_cycle(cpu_bus_pkg::SHIFT_MODE_ADDR, 1'b1, {6'h0, shift, 8'h0}, FC_DATA, rd, dt, vp);
    endtask

    // Edge seen on the falling clock edge, stamped in clk32 cycles
    task automatic wait_edge(input int sel, input logic level, output longint stamp);
        logic prev;
        prev = probe(sel);
        @(negedge clk32);
        while (!(probe(sel) == level && prev != level)) begin
            prev = probe(sel);
            @(negedge clk32);
        end
        stamp = cyc;
    endtask

    task automatic horizontal_case(input string name, input logic pal_bit,
                                   input logic [1:0] shift, input int exp_per,
                                   input int exp_low);
        longint t0, t1, t2, t3;
        set_mode(pal_bit, shift);
        wait_edge(SEL_HSYNC, 1'b0, t0);  // First full line in the new mode follows
        wait_edge(SEL_HSYNC, 1'b0, t1);
        wait_edge(SEL_HSYNC, 1'b1, t2);
        wait_edge(SEL_HSYNC, 1'b0, t3);
        check(t3 - t1 == exp_per * M2_DIV,
              $sformatf("%s line is %0d cycles, expected %0d", name, t3 - t1, exp_per * M2_DIV));
        check(t2 - t1 == exp_low * M2_DIV,
              $sformatf("%s HSYNC low %0d cycles, expected %0d", name, t2 - t1, exp_low * M2_DIV));
    endtask

    // ==========================================================
    // Watchdog
    // ==========================================================
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired at %0d ns before the tests completed", $time);
        $display("sim failed");
        $finish;
    end

    // ==========================================================
    // Stimulus
    // ==========================================================
    initial begin
        cpu_bus_pkg::word_t rd;
        cpu_bus_pkg::addr_t a;
        logic dt, vp, prev_vs, done;
        longint f1, r1, f2, t;
        int run, lines, bad, bad_blank, total;
        porb = 1'b0;
        as_n = 1'b1;
        rw = 1'b1;
        uds_n = 1'b1;
        fc = FC_DATA;
        addr = '0;
        wdata = '0;
        mfpint_n = 1'b1;
        mde60 = 1'b0;
        repeat (10) @(negedge clk32);
        porb = 1'b1;

        // Register access
        bus_cycle(cpu_bus_pkg::SYNC_MODE_ADDR, 1'b1, 16'h0200, FC_DATA, rd, dt, vp);
        check(dt && pal, $sformatf("sync mode write gave DTACK %b PAL %b", dt, pal));
        bus_cycle(cpu_bus_pkg::SYNC_MODE_ADDR, 1'b0, 16'h0000, FC_DATA, rd, dt, vp);
        check(dt && rd[9] && rd[15:10] == 6'h3F && rd[7:0] == 8'hFF,
              $sformatf("sync mode read %h with DTACK %b", rd, dt));
        bus_cycle(cpu_bus_pkg::SHIFT_MODE_ADDR, 1'b1, 16'h0100, FC_DATA, rd, dt, vp);
        check(dt, "no DTACK on shifter mode write");
        bus_cycle(cpu_bus_pkg::SHIFT_MODE_ADDR, 1'b0, 16'h0000, FC_DATA, rd, dt, vp);
        check(dt && rd == 16'hFDFF, $sformatf("shifter mode read %h, expected fdff", rd));
        for (int i = 0; i < 4; i++) begin
            rng = xorshift(rng);
            a = cpu_bus_pkg::addr_t'(rng[22:0]);
            if (a == cpu_bus_pkg::SYNC_MODE_ADDR || a == cpu_bus_pkg::SHIFT_MODE_ADDR)
                a = a ^ 23'h10;
            bus_cycle(a, 1'b0, 16'h0000, FC_DATA, rd, dt, vp);
            check(!dt && rd == 16'hFFFF, $sformatf("address %h read %h dtack %b", a, rd, dt));
        end
        end_test("register access");

        horizontal_case("NTSC", 1'b0, 2'b00, 127, 10);
        horizontal_case("PAL", 1'b1, 2'b00, 128, 10);
        horizontal_case("mono", 1'b0, 2'b10, 56, 6);
        end_test("horizontal timing");

        // PAL frame, measured from VSYNC fall to fall
        set_mode(1'b1, 2'b00);
        wait_edge(SEL_HSYNC, 1'b0, t);
        wait_edge(SEL_VSYNC, 1'b0, f1);
        wait_edge(SEL_VSYNC, 1'b1, r1);
        wait_edge(SEL_VSYNC, 1'b0, f2);
        check(f2 - f1 == FRAME_CYC, $sformatf("PAL frame %0d cycles, expected %0d",
              f2 - f1, FRAME_CYC));
        check(r1 - f1 == 4 * LINE_CYC, $sformatf("VSYNC low %0d cycles, expected %0d",
              r1 - f1, 4 * LINE_CYC));
        end_test("vertical timing");

        // DE runs over the next whole frame
        run = 0;
        lines = 0;
        bad = 0;
        bad_blank = 0;
        done = 1'b0;
        prev_vs = vsync_n;
        while (!done) begin
            @(negedge clk32);
            if (de === 1'b1) run++;
            else if (run != 0) begin
                lines++;
                if (run != 84 * M2_DIV) bad++;
                run = 0;
            end
            if (de === 1'b1 && blank_n !== 1'b1) bad_blank++;      // Blank cuts into display
            if (vsync_n === 1'b0 && blank_n !== 1'b0) bad_blank++;  // VSYNC not blanked
            done = prev_vs && !vsync_n;
            prev_vs = vsync_n;
        end
        check(bad == 0, $sformatf("%0d lines with DE not %0d cycles wide", bad, 84 * M2_DIV));
        check(lines == 200, $sformatf("%0d lines with DE, expected 200", lines));
        check(bad_blank == 0,
              $sformatf("%0d cycles with BLANK_N wrong against DE or VSYNC", bad_blank));
        end_test("display enable");

        // Interrupts
        wait_edge(SEL_VSYNC, 1'b1, t);
        repeat (2) @(negedge clk32);
        check(!ipl2_n, "IPL2 not low after VSYNC rise");
        bus_cycle({20'hFFFFF, cpu_bus_pkg::VBL_LEVEL}, 1'b0, 16'h0, FC_IACK, rd, dt, vp);
        check(vp && !dt, $sformatf("VBL acknowledge gave VPA %b DTACK %b", vp, dt));
        check(ipl2_n, "IPL2 still low after VBL acknowledge");
        wait_edge(SEL_HSYNC, 1'b1, t);
        repeat (2) @(negedge clk32);
        check(!ipl1_n, "IPL1 not low after HSYNC rise");
        bus_cycle({20'hFFFFF, cpu_bus_pkg::HBL_LEVEL}, 1'b0, 16'h0, FC_IACK, rd, dt, vp);
        check(vp, "no VPA on HBL acknowledge");
        check(ipl1_n, "IPL1 still low after HBL acknowledge");
        mfpint_n = 1'b0;
        @(negedge clk32);
        check(!ipl1_n && !ipl2_n, $sformatf("MFP request gave IPL2 %b IPL1 %b", ipl2_n, ipl1_n));
        mfpint_n = 1'b1;
        end_test("interrupts");

        total = errors + gstmcu_video_i.gstmcu_asserts_i.fail_count;
        $display("%0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
                 tests, failed, checks, errors, gstmcu_video_i.gstmcu_asserts_i.fail_count);
        if (total == 0) $display("sim passed");
        else $display("sim failed");
        $finish;
    end

endmodule

// File: compile.f
cpu_bus_pkg.sv
video_timing_pkg.sv
clock_enables.sv
bus_regs.sv
hsync_gen.sv
vsync_gen.sv
de_gen.sv
gstmcu_video.sv
tb_clock.sv
gstmcu_asserts.sv
tb_gstmcu.sv

// File: Makefile
# Verilator simulation of the GSTMCU video timing block

VERILATOR ?= verilator
TOP       ?= tb_gstmcu
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= sim passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
